/* build.f */
+incdir+.
corr_pkg.sv
count_if.sv
pulse_detect.sv
lag_corr_bank.sv
cmd_parser.sv
capture_ctrl.sv
frame_tx.sv
corr_top.sv
tb_corr_top.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module tb_corr_top -o Vtb_corr_top

run: compile
	./obj_dir/Vtb_corr_top | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_corr_top.sv */
`timescale 1ns/100ps
`include "corr_defines.svh"

module tb_corr_top;

	localparam int num_frames = 8;
	localparam int busy_frame = 6; // Gets a second start mid-window.
	localparam int slots = `CORR_LAGS + 1;

	logic intclk = 1'b0;
	logic reset = 1'b1;
	corr_pkg::line_t line_in = '0;
	logic [7:0] cmd_byte = '0;
	logic cmd_strobe = 1'b0;
	logic [7:0] tx_byte;
	logic tx_strobe;
	logic frame_start;
	logic busy;

	integer seed = 57;
	logic [31:0] rnd;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;
	logic quiet = 1'b0;
	logic toggle_mode = 1'b0;
	logic toggle_phase = 1'b0;
	corr_pkg::win_code_t codes [num_frames];
	corr_pkg::line_t masks [num_frames];
	int gaps [num_frames];

	// Reference model state.
	corr_pkg::line_t m_mask;
	corr_pkg::line_t c_prev;
	corr_pkg::line_t e_hist [`CORR_LAGS]; // e_hist[k] is e(t-1-k).
	corr_pkg::count_t m_cnt [`CORR_NUM_CNT];
	corr_pkg::stamp_t m_stamp;
	logic m_in_win = 1'b0;
	int m_left = 0;
	logic [7:0] exp_frame [`CORR_FRAME_BYTES];
	int frames_built = 0;
	int frames_rx = 0;
	logic in_frame = 1'b0;
	int byte_idx = 0;
	int post = 0;

	corr_top DUT (
		.intclk (intclk),
		.reset (reset),
		.line_in (line_in),
		.cmd_byte (cmd_byte),
		.cmd_strobe (cmd_strobe),
		.tx_byte (tx_byte),
		.tx_strobe (tx_strobe),
		.frame_start (frame_start),
		.busy (busy)
	);

	always #5 intclk = ~intclk;

	function automatic corr_pkg::count_t sat_inc(input corr_pkg::count_t v);
		if (v == '1) begin
			return v;
		end
		return v + 1'b1;
	endfunction

	task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task build_frame;
		exp_frame[0] = `CORR_SYNC;
		exp_frame[1] = 8'((`CORR_NUM_LINES - 1) * 16 + `CORR_LAGS - 1);
		exp_frame[2] = m_stamp[31:24];
		exp_frame[3] = m_stamp[23:16];
		exp_frame[4] = m_stamp[15:8];
		exp_frame[5] = m_stamp[7:0];
		for (int i = 0; i < `CORR_NUM_CNT; i++) begin
			exp_frame[`CORR_HDR_BYTES + 2 * i] = m_cnt[i][`CORR_CNT_BITS-1:8];
			exp_frame[`CORR_HDR_BYTES + 2 * i + 1] = m_cnt[i][7:0];
		end
		frames_built++;
	endtask

	// Model sees the same inputs as the DUT at each edge.
	always @(posedge intclk) begin : model
		corr_pkg::line_t c_now;
		corr_pkg::line_t e_now;
		logic win_end;
		win_end = 1'b0;
		if (reset) begin
			m_mask = '0;
			c_prev = '0;
			m_stamp = '0;
			m_in_win = 1'b0;
			for (int k = 0; k < `CORR_LAGS; k++) begin
				e_hist[k] = '0;
			end
		end else begin
			c_now = line_in ^ m_mask;
			e_now = c_now & ~c_prev;
			if (m_in_win) begin
				for (int l = 0; l < `CORR_NUM_LINES; l++) begin
					if (e_now[l]) begin
						m_cnt[l * slots] = sat_inc(m_cnt[l * slots]);
						for (int k = 0; k < `CORR_LAGS; k++) begin
							if (e_hist[k][l]) begin
								m_cnt[l * slots + k + 1] = sat_inc(m_cnt[l * slots + k + 1]);
							end
						end
					end
				end
				m_left--;
				if (m_left == 0) begin
					m_in_win = 1'b0;
					win_end = 1'b1;
				end
			end
			for (int k = `CORR_LAGS - 1; k > 0; k--) begin
				e_hist[k] = e_hist[k-1];
			end
			e_hist[0] = e_now;
			c_prev = c_now;
			if (cmd_strobe && (cmd_byte[7:6] == 2'b10)) begin
				m_stamp = '0;
			end else begin
				m_stamp = m_stamp + 32'd1;
			end
			if (win_end) begin
				build_frame();
			end
			if (cmd_strobe && (cmd_byte[7:6] == 2'b00)) begin
				m_mask = cmd_byte[3:0];
			end
			if (cmd_strobe && (cmd_byte[7:6] == 2'b01) && !m_in_win
					&& (frames_built == frames_rx)) begin
				for (int i = 0; i < `CORR_NUM_CNT; i++) begin
					m_cnt[i] = '0;
				end
				m_in_win = 1'b1;
				m_left = (int'(cmd_byte[5:0]) + 1) * 16;
			end
		end
	end

	// Frame collector and level checks.
	always @(negedge intclk) begin
		if (!reset) begin
			if (quiet) begin
				compare_value("busy", 32'(busy), 32'd0);
				compare_value("tx_strobe", 32'(tx_strobe), 32'd0);
				compare_value("frame_start", 32'(frame_start), 32'd0);
			end
			if (m_in_win || (frames_built > frames_rx)) begin
				compare_value("busy", 32'(busy), 32'd1);
			end
			if (post == 1) begin
				compare_value("busy", 32'(busy), 32'd1);
				post = 2;
			end else if (post == 2) begin
				compare_value("busy", 32'(busy), 32'd0); // Falls a cycle after idle.
				post = 0;
			end
			if (tx_strobe) begin
				if (frame_start) begin
					if (in_frame) begin
						errors++;
						$display("frame restarted after %0d bytes at %0t", byte_idx, $time);
					end
					if (frames_built <= frames_rx) begin
						errors++;
						$display("frame sent without a finished capture at %0t", $time);
					end
					in_frame = 1'b1;
					byte_idx = 0;
				end else if (!in_frame) begin
					errors++;
					$display("byte strobe outside a frame at %0t", $time);
				end
				if (in_frame) begin
					compare_value($sformatf("tx_byte[%0d]", byte_idx), 32'(tx_byte),
						32'(exp_frame[byte_idx]));
					byte_idx++;
					if (byte_idx == `CORR_FRAME_BYTES) begin
						in_frame = 1'b0;
						frames_rx++;
						post = 1;
					end
				end
			end else begin
				compare_value("frame_start", 32'(frame_start), 32'd0);
				if (in_frame) begin
					errors++;
					$display("strobe gap after %0d frame bytes at %0t", byte_idx, $time);
					in_frame = 1'b0;
				end
			end
		end
	end

	always @(posedge intclk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Lines change 1 ns after each edge.
	task step;
		@(posedge intclk);
		#1;
		rnd = $random(seed);
		if (!toggle_mode) begin
			line_in = rnd[3:0];
		end else begin
			toggle_phase = !toggle_phase;
			if (toggle_phase) begin
				line_in = ~line_in;
			end
		end
	endtask

	task send_cmd(input logic [7:0] b);
		step();
		cmd_byte = b;
		cmd_strobe = 1'b1;
		step();
		cmd_strobe = 1'b0;
		cmd_byte = '0;
	endtask

	task run_capture(input int i);
		toggle_mode = (i == num_frames - 1);
		send_cmd({4'b0000, masks[i]});
		if (i != num_frames - 1) begin
			send_cmd(8'h80); // Timestamp clear.
			repeat (gaps[i]) step();
		end
		send_cmd({2'b01, codes[i]});
		if (i == busy_frame) begin
			repeat (gaps[i] % 8) step();
			send_cmd({2'b01, codes[0]}); // Lands inside the window.
		end
		step();
		while (busy) step();
		if (i == busy_frame) begin
			repeat (60) step();
		end
	endtask

	initial begin
		int total;
		total = 0;
		for (int i = 0; i < num_frames; i++) begin
			rnd = $random(seed);
			codes[i] = rnd[5:0];
			masks[i] = rnd[11:8];
			gaps[i] = int'(rnd[19:16]);
		end
		masks[2] = '1;
		masks[7] = '0;
		codes[7] = '1; // Longest window of 1024 samples.
		for (int i = 0; i < num_frames; i++) begin
			total += (int'(codes[i]) + 1) * 16;
		end
		limit = total + 100 * num_frames + 400;
		repeat (8) step();
		reset = 1'b0;
		quiet = 1'b1;
		repeat (10) step();
		rnd = $random(seed);
		send_cmd({2'b11, rnd[5:0]});
		repeat (60) step();
		quiet = 1'b0;
		for (int i = 0; i < num_frames; i++) begin
			run_capture(i);
		end
		repeat (20) step();
		if ((frames_rx != frames_built) || (frames_rx != num_frames)) begin
			$display("wrong number of frames, %0d received for %0d captures",
				frames_rx, num_frames);
		end
		$display("checks %0d, errors %0d, frames %0d", checks, errors, frames_rx);
		if ((errors == 0) && (frames_rx == frames_built) && (frames_rx == num_frames)) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* corr_top.sv */
`timescale 1ns/100ps

module corr_top (
	input logic intclk,
	input logic reset,
	input corr_pkg::line_t line_in,
	input logic [7:0] cmd_byte,
	input logic cmd_strobe,
	output logic [7:0] tx_byte,
	output logic tx_strobe,
	output logic frame_start,
	output logic busy
);

	corr_pkg::line_t invert;
	corr_pkg::line_t edges;
	corr_pkg::win_code_t win_code;
	corr_pkg::stamp_t stamp;
	logic start;
	logic stamp_clear;
	logic dump;
	logic done;

	count_if cnt_bus ();

	pulse_detect u_pulse_detect (
		.intclk (intclk),
		.reset (reset),
		.line_in (line_in),
		.invert (invert),
		.edges (edges)
	);

	lag_corr_bank u_lag_corr_bank (
		.intclk (intclk),
		.reset (reset),
		.edges (edges),
		.cnt (cnt_bus.bank)
	);

	cmd_parser u_cmd_parser (
		.intclk (intclk),
		.reset (reset),
		.cmd_byte (cmd_byte),
		.cmd_strobe (cmd_strobe),
		.invert (invert),
		.start (start),
		.win_code (win_code),
		.stamp_clear (stamp_clear)
	);

	capture_ctrl u_capture_ctrl (
		.intclk (intclk),
		.reset (reset),
		.start (start),
		.win_code (win_code),
		.stamp_clear (stamp_clear),
		.done (done),
		.cnt (cnt_bus.ctrl),
		.dump (dump),
		.stamp (stamp),
		.busy (busy)
	);

	frame_tx u_frame_tx (
		.intclk (intclk),
		.reset (reset),
		.dump (dump),
		.stamp (stamp),
		.cnt (cnt_bus.reader),
		.tx_byte (tx_byte),
		.tx_strobe (tx_strobe),
		.frame_start (frame_start),
		.done (done)
	);

endmodule

/* frame_tx.sv */
`timescale 1ns/100ps
`include "corr_defines.svh"

module frame_tx (
	input logic intclk,
	input logic reset,
	input logic dump,
	input corr_pkg::stamp_t stamp,
	count_if.reader cnt,
	output logic [7:0] tx_byte,
	output logic tx_strobe,
	output logic frame_start,
	output logic done
);

	localparam logic [5:0] last_idx = 6'(`CORR_FRAME_BYTES - 1);
	localparam logic [5:0] hdr_bytes = 6'(`CORR_HDR_BYTES);
	localparam logic [7:0] cfg_byte = {4'(`CORR_NUM_LINES - 1), 4'(`CORR_LAGS - 1)};

	logic active;
	logic [5:0] idx;
	logic [7:0] next_byte;
	corr_pkg::cnt_sel_t sel_q;

	assign cnt.sel = sel_q;

	always_comb begin
		case (idx)
			6'd0: next_byte = `CORR_SYNC;
			6'd1: next_byte = cfg_byte;
			6'd2: next_byte = stamp[31:24]; // Timestamp MSB first.
			6'd3: next_byte = stamp[23:16];
			6'd4: next_byte = stamp[15:8];
			6'd5: next_byte = stamp[7:0];
			// Even offsets carry the high byte.
			default: next_byte = idx[0] ? cnt.data[7:0] : cnt.data[`CORR_CNT_BITS-1:8];
		endcase
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			active <= 1'b0;
			idx <= '0;
			sel_q <= '0;
			tx_strobe <= 1'b0;
			frame_start <= 1'b0;
			done <= 1'b0;
		end else begin
			tx_strobe <= active;
			frame_start <= active && (idx == '0);
			done <= active && (idx == last_idx);
			if (dump && !active) begin
				active <= 1'b1;
				idx <= '0;
				sel_q <= '0;
			end else if (active) begin
				idx <= idx + 1'b1;
				if (idx == last_idx) begin
					active <= 1'b0;
				end
				// Next counter after its low byte.
				if ((idx >= hdr_bytes) && idx[0] && (idx != last_idx)) begin
					sel_q <= sel_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge intclk) begin
		tx_byte <= next_byte;
	end

endmodule

/* capture_ctrl.sv */
`timescale 1ns/100ps

module capture_ctrl (
	input logic intclk,
	input logic reset,
	input logic start,
	input corr_pkg::win_code_t win_code,
	input logic stamp_clear,
	input logic done,
	count_if.ctrl cnt,
	output logic dump,
	output corr_pkg::stamp_t stamp,
	output logic busy
);

	corr_pkg::cap_state_t state;
	corr_pkg::win_code_t code_q;
	corr_pkg::stamp_t stamp_cnt;
	logic [6:0] blocks;
	logic [10:0] win_len;
	logic [10:0] win_cnt;
	logic run_q;
	logic accept;

	assign accept = start && (state == corr_pkg::cap_idle) && !busy;

	// Window of (code + 1) * 16 samples.
	assign blocks = {1'b0, code_q} + 7'd1;
	assign win_len = {blocks, 4'b0000};

	assign cnt.clear = accept; // Counters zero at the accepting edge.
	assign cnt.run = run_q;

	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= corr_pkg::cap_idle;
			win_cnt <= '0;
			run_q <= 1'b0;
			dump <= 1'b0;
			busy <= 1'b0;
		end else begin
			run_q <= 1'b0;
			dump <= 1'b0;
			busy <= accept || (state != corr_pkg::cap_idle);
			case (state)
				corr_pkg::cap_idle: begin
					if (accept) begin
						state <= corr_pkg::cap_integrate;
						win_cnt <= '0;
					end
				end
				corr_pkg::cap_integrate: begin
					win_cnt <= win_cnt + 1'b1;
					run_q <= (win_cnt < win_len); // One cycle behind the samples.
					if (win_cnt == win_len + 11'd1) begin
						state <= corr_pkg::cap_dump;
						dump <= 1'b1;
					end
				end
				corr_pkg::cap_dump: begin
					if (done) begin
						state <= corr_pkg::cap_idle;
					end
				end
				default: state <= corr_pkg::cap_idle;
			endcase
		end
	end

	always_ff @(posedge intclk) begin
		if (accept) begin
			code_q <= win_code;
		end
	end

	// Free-running edge count.
	always_ff @(posedge intclk) begin
		if (reset || stamp_clear) begin
			stamp_cnt <= '0;
		end else begin
			stamp_cnt <= stamp_cnt + 1'b1;
		end
	end

	// Value as of the last window sample edge.
	always_ff @(posedge intclk) begin
		if ((state == corr_pkg::cap_integrate) && (win_cnt == win_len)) begin
			stamp <= stamp_cnt;
		end
	end

endmodule

/* cmd_parser.sv */
`timescale 1ns/100ps
`include "corr_defines.svh"

module cmd_parser (
	input logic intclk,
	input logic reset,
	input logic [7:0] cmd_byte,
	input logic cmd_strobe,
	output corr_pkg::line_t invert,
	output logic start,
	output corr_pkg::win_code_t win_code,
	output logic stamp_clear
);

	localparam logic [1:0] op_mask = 2'b00;
	localparam logic [1:0] op_start = 2'b01;
	localparam logic [1:0] op_clear = 2'b10;

	logic [1:0] opcode;

	assign opcode = cmd_byte[7:6];

	// Opcode 11 decodes to nothing.
	assign start = cmd_strobe && (opcode == op_start);
	assign stamp_clear = cmd_strobe && (opcode == op_clear);
	assign win_code = cmd_byte[`CORR_CODE_BITS-1:0];

	always_ff @(posedge intclk) begin
		if (reset) begin
			invert <= '0;
		end else if (cmd_strobe && (opcode == op_mask)) begin
			invert <= cmd_byte[`CORR_NUM_LINES-1:0]; // Low nibble.
		end
	end

endmodule

/* lag_corr_bank.sv */
`timescale 1ns/100ps
`include "corr_defines.svh"

module lag_corr_bank (
	input logic intclk,
	input logic reset,
	input corr_pkg::line_t edges,
	count_if.bank cnt
);

	localparam int slots = `CORR_LAGS + 1;

	corr_pkg::line_t hist [`CORR_LAGS]; // hist[k] holds e(t-1-k).
	corr_pkg::count_t counters [`CORR_NUM_CNT];
	logic [`CORR_NUM_CNT-1:0] hit;

	// Increment requests in counter index order.
	always_comb begin
		for (int l = 0; l < `CORR_NUM_LINES; l++) begin
			hit[l*slots] = edges[l]; // Pulse count slot.
			for (int k = 0; k < `CORR_LAGS; k++) begin
				hit[l*slots+k+1] = edges[l] & hist[k][l];
			end
		end
	end

	// History runs outside the window too.
	always_ff @(posedge intclk) begin
		if (reset) begin
			for (int k = 0; k < `CORR_LAGS; k++) begin
				hist[k] <= '0;
			end
		end else begin
			hist[0] <= edges;
			for (int k = 1; k < `CORR_LAGS; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	always_ff @(posedge intclk) begin
		for (int i = 0; i < `CORR_NUM_CNT; i++) begin
			if (cnt.clear) begin
				counters[i] <= '0;
			end else if (cnt.run && hit[i] && (counters[i] != '1)) begin
				counters[i] <= counters[i] + 1'b1; // Saturates at all ones.
			end
		end
	end

	assign cnt.data = counters[cnt.sel];

endmodule

/* pulse_detect.sv */
`timescale 1ns/100ps

module pulse_detect (
	input logic intclk,
	input logic reset,
	input corr_pkg::line_t line_in,
	input corr_pkg::line_t invert,
	output corr_pkg::line_t edges
);

	corr_pkg::line_t cond;
	corr_pkg::line_t cur_q;
	corr_pkg::line_t prev_q;

	assign cond = line_in ^ invert; // Conditioned sample.

	always_ff @(posedge intclk) begin
		if (reset) begin
			cur_q <= '0;
			prev_q <= '0;
		end else begin
			cur_q <= cond;
			prev_q <= cur_q;
		end
	end

	// Rising edge of the registered sample.
	assign edges = cur_q & ~prev_q;

endmodule

/* count_if.sv */
`timescale 1ns/100ps

interface count_if;

	logic clear; // Zero all counters.
	logic run; // Counting enable, aligned to edge flags.
	corr_pkg::cnt_sel_t sel;
	corr_pkg::count_t data; // Combinational from sel.

	modport ctrl (
		output clear,
		output run
	);

	modport reader (
		output sel,
		input data
	);

	modport bank (
		input clear,
		input run,
		input sel,
		output data
	);

endinterface

/* corr_pkg.sv */
`include "corr_defines.svh"

package corr_pkg;

	// One bit per detector line.
	typedef logic [`CORR_NUM_LINES-1:0] line_t;

	typedef logic [`CORR_CNT_BITS-1:0] count_t;

	typedef logic [$clog2(`CORR_NUM_CNT)-1:0] cnt_sel_t; // Counter index.

	typedef logic [`CORR_STAMP_BITS-1:0] stamp_t;

	typedef logic [`CORR_CODE_BITS-1:0] win_code_t; // Window is (code + 1) * 16.

	typedef enum logic [1:0] {
		cap_idle,
		cap_integrate,
		cap_dump
	} cap_state_t;

endpackage

/* corr_defines.svh */
`ifndef CORR_DEFINES_SVH
`define CORR_DEFINES_SVH

// Detector lines and autocorrelation taps per line.
`define CORR_NUM_LINES 4
`define CORR_LAGS 4

`define CORR_CNT_BITS 16 // Saturating counter width.
`define CORR_NUM_CNT 20 // Lines times (lags + 1).

`define CORR_STAMP_BITS 32
`define CORR_CODE_BITS 6 // Window length code.

// Frame layout.
`define CORR_SYNC 8'hA5
`define CORR_HDR_BYTES 6 // Sync, config, four stamp bytes.
`define CORR_FRAME_BYTES 46

`endif
